//--- common/cart_macros.svh
// Width and geometry constants for the cartridge slot mapper.
// Include this wherever a width, the SFG window or ASCII8 page layout is needed.

`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Bus widths
`define CART_MEM_ADDR_W 27
`define CART_CPU_ADDR_W 16
`define CART_DATA_W 8

// Yamaha SFG device register window, repeated in each 16 KB mirror
`define CART_SFG_WIN_BASE 14'h3FF0

// ASCII8 geometry: four 8 KB pages, each with its own bank register
`define CART_ASCII8_BANKS 4
`define CART_ASCII8_PAGE_BITS 13
`define CART_BANK_W 8

// Address driven when no memory access is in progress
`define CART_IDLE_ADDR {`CART_MEM_ADDR_W{1'b1}}

`endif

//--- common/cart_pkg.sv
// Shared types for the cartridge slot mapper.
// Modules refer to these by scoped names such as cart_pkg::mem_addr_t.
// Widths come from the macros header so both stay in step.

`default_nettype none

`include "cart_macros.svh"

package cart_pkg;

    // CPU bus address as seen on the slot
    typedef logic [`CART_CPU_ADDR_W-1:0] cpu_addr_t;

    // One data byte, used for CPU and sound device traffic alike
    typedef logic [`CART_DATA_W-1:0] cpu_data_t;

    // Byte address into the external cartridge memory
    typedef logic [`CART_MEM_ADDR_W-1:0] mem_addr_t;

    // ROM size in bytes
    // Always a power of two, so size minus one is the address mask
    typedef logic [`CART_MEM_ADDR_W-1:0] rom_size_t;

    // ASCII8 bank number as written by the CPU
    typedef logic [`CART_BANK_W-1:0] bank_t;

    // Mapper type selected through the configuration port
    // NONE leaves the slot silent: no memory and no device access
    typedef enum logic [1:0] {
        MAPPER_NONE       = 2'd0,
        MAPPER_YAMAHA_SFG = 2'd1,
        MAPPER_ASCII8     = 2'd2
    } mapper_typ_e;

endpackage

`default_nettype wire

//--- src/slot_decode.sv
// Configuration registers and mapper select decoding for the cartridge slot.
// The configuration port loads the mapper type and ROM size on a cfg_we pulse,
// and each CPU mreq is steered to the one mapper matching the stored type.

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module slot_decode (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  cfg_we,
    input  cart_pkg::mapper_typ_e      cfg_typ,
    input  cart_pkg::rom_size_t        cfg_rom_size,
    input  wire logic                  mreq,
    output logic                       sfg_cs,
    output logic                       ascii8_cs,
    output cart_pkg::rom_size_t        rom_size
);

    // Stored configuration
    cart_pkg::mapper_typ_e typ_q;
    cart_pkg::rom_size_t   rom_size_q;

    // A cfg_we pulse takes effect on the following cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            typ_q      <= cart_pkg::MAPPER_NONE;
            rom_size_q <= '0;
        end else if (cfg_we) begin
            typ_q      <= cfg_typ;
            rom_size_q <= cfg_rom_size;
        end
    end

    // One select per mapper, qualified by the memory request strobe
    assign sfg_cs    = (typ_q == cart_pkg::MAPPER_YAMAHA_SFG) && mreq;
    assign ascii8_cs = (typ_q == cart_pkg::MAPPER_ASCII8) && mreq;

    // Both mappers see the same ROM size
    assign rom_size = rom_size_q;

    // The result stage relies on at most one mapper being active
    a_cs_onehot0 : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(sfg_cs && ascii8_cs)
    ) else $error("slot_decode: both mapper selects high");

endmodule

`default_nettype wire

//--- src/mapper/mapper_yamaha_sfg.sv
// Yamaha SFG cartridge mapper.
// A plain 16-bit ROM window, except for offsets 3FF0 to 3FF7 of every 16 KB
// mirror, which reach the sound unit registers. Purely combinational; the
// result stage registers everything it produces.

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module mapper_yamaha_sfg (
    input  wire logic                  cs,
    input  wire logic                  rd,
    input  wire logic                  wr,
    input  cart_pkg::cpu_addr_t        addr,
    input  cart_pkg::rom_size_t        rom_size,
    output logic                       rom_cs,
    output cart_pkg::mem_addr_t        rom_addr,
    output logic                       dev_en,
    output logic                       dev_we
);

    localparam logic [13:0] WIN_BASE = `CART_SFG_WIN_BASE;

    // Eight byte register window, matched on the upper offset bits
    logic                  win_hit;
    // Access falls into ROM, before read qualification
    logic                  rom_hit;
    // ROM mask derived from the configured size
    cart_pkg::cpu_addr_t   rom_mask;

    assign win_hit = (addr[13:3] == WIN_BASE[13:3]);

    always_comb begin
        dev_en  = 1'b0;
        dev_we  = 1'b0;
        rom_hit = 1'b0;
        if (cs) begin
            if (win_hit) begin
                case (addr[2:0])
                    // Address and data ports of the sound unit
                    3'd0,
                    3'd1: dev_en = rd || wr;
                    // Control registers accept writes only
                    3'd3,
                    3'd4,
                    3'd5,
                    3'd6: dev_we = wr;
                    // 3FF2 and 3FF7 are unused holes in the window
                    default: ;
                endcase
            end else begin
                rom_hit = 1'b1;
            end
        end
    end

    // ROM is read only, so writes outside the window are dropped
    assign rom_cs = rom_hit && rd;

    // Only the low 16 bits of size matter since the window is 64 KB at most
    assign rom_mask = rom_size[`CART_CPU_ADDR_W-1:0] - `CART_CPU_ADDR_W'd1;

    // Masked CPU address, zero extended, or the idle pattern
    assign rom_addr = rom_cs
                    ? {{(`CART_MEM_ADDR_W-`CART_CPU_ADDR_W){1'b0}}, addr & rom_mask}
                    : `CART_IDLE_ADDR;

    // A single access reaches either the enable or the write strobe
    always_comb begin
        a_dev_excl : assert final (!(dev_en && dev_we))
            else $error("mapper_yamaha_sfg: dev_en and dev_we together");
    end

endmodule

`default_nettype wire

//--- src/mapper/mapper_ascii8.sv
// ASCII8 cartridge mapper.
// Four 8 KB pages at 4000, 6000, 8000 and A000, each with a bank register
// loaded by CPU writes to 6000-7FFF. Reads in 4000-BFFF produce a banked ROM
// address masked to the configured size.

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module mapper_ascii8 (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  cs,
    input  wire logic                  rd,
    input  wire logic                  wr,
    input  cart_pkg::cpu_addr_t        addr,
    input  cart_pkg::cpu_data_t        wdata,
    input  cart_pkg::rom_size_t        rom_size,
    output logic                       rom_cs,
    output cart_pkg::mem_addr_t        rom_addr
);

    localparam int PAGE_BITS = `CART_ASCII8_PAGE_BITS;
    localparam int PAD_BITS  = `CART_MEM_ADDR_W - `CART_BANK_W - PAGE_BITS;

    // Bank registers, index 0 serving the page at 4000
    cart_pkg::bank_t [`CART_ASCII8_BANKS-1:0] banks;

    // Bank write decode
    logic                  bank_we;
    logic [1:0]            bank_wsel;

    // Read decode and page lookup
    logic [2:0]            page_num;
    logic                  page_hit;
    logic [1:0]            page_sel;
    cart_pkg::mem_addr_t   rom_mask;
    cart_pkg::mem_addr_t   banked_addr;

    // Writes to 6000-7FFF, split into four 2 KB register areas
    assign bank_we   = cs && wr && (addr[15:13] == 3'b011);
    assign bank_wsel = addr[12:11];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            banks <= '0;
        end else if (bank_we) begin
            banks[bank_wsel] <= wdata;
        end
    end

    // Pages 2 to 5 of the CPU space are the four switched pages
    assign page_num = addr[15:13];
    assign page_hit = (page_num >= 3'd2) && (page_num <= 3'd5);
    assign page_sel = 2'(page_num - 3'd2);

    // Only reads reach ROM; bank register writes never touch memory
    assign rom_cs = cs && rd && page_hit;

    // Bank number on top of the in-page offset
    assign banked_addr = {{PAD_BITS{1'b0}}, banks[page_sel], addr[PAGE_BITS-1:0]};

    // A ROM smaller than the bank range wraps, as on real cartridges
    assign rom_mask = rom_size - `CART_MEM_ADDR_W'd1;

    assign rom_addr = rom_cs ? (banked_addr & rom_mask) : `CART_IDLE_ADDR;

    // Bank state only moves on a selected CPU write
    a_bank_hold : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(cs && wr) |=> $stable(banks)
    ) else $error("mapper_ascii8: bank changed without a selected write");

endmodule

`default_nettype wire

//--- src/slot_result.sv
// Result stage of the cartridge slot.
// Merges the mapper outputs into one memory or device request, registers it
// for one cycle and returns CPU read data from whichever source was accessed.
// Unselected mappers drive idle values, so no mapper type is tested here.

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module slot_result (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  wr,
    input  cart_pkg::cpu_data_t        wdata,
    input  wire logic                  sfg_rom_cs,
    input  cart_pkg::mem_addr_t        sfg_rom_addr,
    input  wire logic                  sfg_dev_en,
    input  wire logic                  sfg_dev_we,
    input  wire logic                  a8_rom_cs,
    input  cart_pkg::mem_addr_t        a8_rom_addr,
    input  cart_pkg::cpu_data_t        mem_rdata,
    input  cart_pkg::cpu_data_t        dev_rdata,
    output logic                       mem_cs,
    output logic                       mem_rnw,
    output cart_pkg::mem_addr_t        mem_addr,
    output logic                       dev_en,
    output logic                       dev_we,
    output cart_pkg::cpu_data_t        dev_wdata,
    output cart_pkg::cpu_data_t        rdata
);

    // Merged request before the register
    logic                  mem_cs_d;
    cart_pkg::mem_addr_t   mem_addr_d;
    logic                  dev_rd_d;

    // Registered device read flag, steers rdata
    logic                  dev_rd_q;

    // At most one mapper is selected, so an OR merges the selects
    assign mem_cs_d = sfg_rom_cs || a8_rom_cs;

    // Address from the mapper that owns the access
    always_comb begin
        if (sfg_rom_cs) begin
            mem_addr_d = sfg_rom_addr;
        end else if (a8_rom_cs) begin
            mem_addr_d = a8_rom_addr;
        end else begin
            mem_addr_d = `CART_IDLE_ADDR;
        end
    end

    // Device read: enable raised by a read rather than a write
    assign dev_rd_d = sfg_dev_en && !wr;

    // Request register, one cycle after the CPU strobes are sampled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_cs   <= 1'b0;
            mem_addr <= `CART_IDLE_ADDR;
            dev_en   <= 1'b0;
            dev_we   <= 1'b0;
            dev_rd_q <= 1'b0;
        end else begin
            mem_cs   <= mem_cs_d;
            mem_addr <= mem_addr_d;
            dev_en   <= sfg_dev_en;
            dev_we   <= sfg_dev_we;
            dev_rd_q <= dev_rd_d;
        end
    end

    // Write data follows the strobes and only matters while dev_we is high
    always_ff @(posedge clk) begin
        dev_wdata <= wdata;
    end

    // Cartridge memory is ROM, every memory request is a read
    assign mem_rnw = 1'b1;

    // Device data first, then ROM data, otherwise an open bus
    always_comb begin
        if (dev_rd_q) begin
            rdata = dev_rdata;
        end else if (mem_cs) begin
            rdata = mem_rdata;
        end else begin
            rdata = '1;
        end
    end

    // Memory and device requests come from disjoint address decodes
    a_req_excl : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_cs && dev_en)
    ) else $error("slot_result: mem_cs and dev_en together");

endmodule

`default_nettype wire

//--- src/cart_slot_top.sv
// Top level of the cartridge slot mapper.
// Connects configuration decode, the SFG and ASCII8 mappers and the result
// stage. CPU strobes are sampled each clock; requests leave one cycle later.

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module cart_slot_top (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    // Configuration port
    input  wire logic                  cfg_we,
    input  cart_pkg::mapper_typ_e      cfg_typ,
    input  cart_pkg::rom_size_t        cfg_rom_size,
    // CPU bus
    input  wire logic                  mreq,
    input  wire logic                  rd,
    input  wire logic                  wr,
    input  cart_pkg::cpu_addr_t        addr,
    input  cart_pkg::cpu_data_t        wdata,
    output cart_pkg::cpu_data_t        rdata,
    // Cartridge memory
    output logic                       mem_cs,
    output logic                       mem_rnw,
    output cart_pkg::mem_addr_t        mem_addr,
    input  cart_pkg::cpu_data_t        mem_rdata,
    // Sound unit device bus
    output logic                       dev_en,
    output logic                       dev_we,
    output cart_pkg::cpu_data_t        dev_wdata,
    input  cart_pkg::cpu_data_t        dev_rdata
);

    // Decode to mappers
    logic                  sfg_cs;
    logic                  ascii8_cs;
    cart_pkg::rom_size_t   rom_size;

    // Mappers to result
    logic                  sfg_rom_cs;
    cart_pkg::mem_addr_t   sfg_rom_addr;
    logic                  sfg_dev_en;
    logic                  sfg_dev_we;
    logic                  a8_rom_cs;
    cart_pkg::mem_addr_t   a8_rom_addr;

    slot_decode decode_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_we       (cfg_we),
        .cfg_typ      (cfg_typ),
        .cfg_rom_size (cfg_rom_size),
        .mreq         (mreq),
        .sfg_cs       (sfg_cs),
        .ascii8_cs    (ascii8_cs),
        .rom_size     (rom_size)
    );

    mapper_yamaha_sfg sfg_i (
        .cs       (sfg_cs),
        .rd       (rd),
        .wr       (wr),
        .addr     (addr),
        .rom_size (rom_size),
        .rom_cs   (sfg_rom_cs),
        .rom_addr (sfg_rom_addr),
        .dev_en   (sfg_dev_en),
        .dev_we   (sfg_dev_we)
    );

    mapper_ascii8 ascii8_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .cs       (ascii8_cs),
        .rd       (rd),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .rom_size (rom_size),
        .rom_cs   (a8_rom_cs),
        .rom_addr (a8_rom_addr)
    );

    slot_result result_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr           (wr),
        .wdata        (wdata),
        .sfg_rom_cs   (sfg_rom_cs),
        .sfg_rom_addr (sfg_rom_addr),
        .sfg_dev_en   (sfg_dev_en),
        .sfg_dev_we   (sfg_dev_we),
        .a8_rom_cs    (a8_rom_cs),
        .a8_rom_addr  (a8_rom_addr),
        .mem_rdata    (mem_rdata),
        .dev_rdata    (dev_rdata),
        .mem_cs       (mem_cs),
        .mem_rnw      (mem_rnw),
        .mem_addr     (mem_addr),
        .dev_en       (dev_en),
        .dev_we       (dev_we),
        .dev_wdata    (dev_wdata),
        .rdata        (rdata)
    );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// Clock and reset source for the cartridge slot testbench.
// Runs a free clock and releases the active-low reset on a falling edge.

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the rising edge so the first sampled cycle is clean
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/tb_cart_slot.sv
// Testbench for the cartridge slot mapper.
// Drives random CPU traffic on falling edges, predicts every registered request
// and rdata with a model of the SFG and ASCII8 mappers, and checks each cycle.

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module tb_cart_slot;

    localparam logic [13:0] SFG_WIN = `CART_SFG_WIN_BASE;
    localparam int IDLE_CYCLES  = 200;
    localparam int SFG_SIZES    = 5;
    localparam int SFG_READS    = 120;
    localparam int WIN_CYCLES   = 300;
    localparam int A8_ROUNDS    = 4;
    localparam int A8_WRITES    = 8;
    localparam int A8_READS     = 120;
    localparam int BURSTS       = 8;
    localparam int BURST_LEN    = 60;
    // Reset, every phase including its configuration cycles, flush, then a margin
    localparam int CYCLE_LIMIT = 16 + IDLE_CYCLES + SFG_SIZES * (1 + SFG_READS)
                               + 1 + WIN_CYCLES + 1 + A8_ROUNDS * (A8_WRITES + A8_READS)
                               + BURSTS * (1 + BURST_LEN) + 2 + 200;

    logic clk;
    logic arst_n;
    logic cfg_we;
    cart_pkg::mapper_typ_e cfg_typ;
    cart_pkg::rom_size_t cfg_rom_size;
    logic mreq;
    logic rd;
    logic wr;
    cart_pkg::cpu_addr_t addr;
    cart_pkg::cpu_data_t wdata;
    cart_pkg::cpu_data_t rdata;
    logic mem_cs;
    logic mem_rnw;
    cart_pkg::mem_addr_t mem_addr;
    cart_pkg::cpu_data_t mem_rdata;
    logic dev_en;
    logic dev_we;
    cart_pkg::cpu_data_t dev_wdata;
    cart_pkg::cpu_data_t dev_rdata;

    // Model state holding the configuration and ASCII8 banks as the DUT should
    cart_pkg::mapper_typ_e m_typ;
    cart_pkg::rom_size_t m_size;
    cart_pkg::bank_t m_banks [`CART_ASCII8_BANKS];

    // Expected registered request for the access presented last cycle
    logic exp_mem_cs;
    cart_pkg::mem_addr_t exp_mem_addr;
    logic exp_dev_en;
    logic exp_dev_we;
    logic exp_dev_rd;
    cart_pkg::cpu_data_t exp_dev_wdata;

    logic [31:0] lfsr_q;
    int cycle_cnt;

    tb_clk_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cart_slot_top dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_we       (cfg_we),
        .cfg_typ      (cfg_typ),
        .cfg_rom_size (cfg_rom_size),
        .mreq         (mreq),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .mem_cs       (mem_cs),
        .mem_rnw      (mem_rnw),
        .mem_addr     (mem_addr),
        .mem_rdata    (mem_rdata),
        .dev_en       (dev_en),
        .dev_we       (dev_we),
        .dev_wdata    (dev_wdata),
        .dev_rdata    (dev_rdata)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit with the newest bit in the LSB
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits = {bits[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_request();
        check_value("mem_cs", mem_cs, exp_mem_cs);
        check_value("mem_rnw", mem_rnw, 1);
        check_value("mem_addr", mem_addr, exp_mem_addr);
        check_value("dev_en", dev_en, exp_dev_en);
        check_value("dev_we", dev_we, exp_dev_we);
        // Write data is only defined alongside a device write
        if (exp_dev_we) begin
            check_value("dev_wdata", dev_wdata, exp_dev_wdata);
        end
    endtask

    // Predict the request this access produces and then apply its bank write
    task automatic predict(input logic mreq_v, input logic rd_v, input logic wr_v,
                           input cart_pkg::cpu_addr_t a, input cart_pkg::cpu_data_t d);
        logic [15:0] mask16;
        logic [2:0] page;
        logic [1:0] idx;
        exp_mem_cs = 1'b0;
        exp_mem_addr = `CART_IDLE_ADDR;
        exp_dev_en = 1'b0;
        exp_dev_we = 1'b0;
        exp_dev_wdata = d;
        page = a[15:13];
        // Adding 2 modulo 4 maps pages 2 to 5 onto banks 0 to 3
        idx = page[1:0] + 2'd2;
        if (mreq_v && m_typ == cart_pkg::MAPPER_YAMAHA_SFG) begin
            if (a[13:3] == SFG_WIN[13:3]) begin
                if (a[2:0] <= 3'd1) begin
                    exp_dev_en = rd_v || wr_v;
                end else if (a[2:0] >= 3'd3 && a[2:0] <= 3'd6) begin
                    exp_dev_we = wr_v;
                end
            end else if (rd_v) begin
                mask16 = m_size[15:0] - 16'd1;
                exp_mem_cs = 1'b1;
                exp_mem_addr = {11'd0, a & mask16};
            end
        end else if (mreq_v && m_typ == cart_pkg::MAPPER_ASCII8) begin
            if (rd_v && page >= 3'd2 && page <= 3'd5) begin
                exp_mem_cs = 1'b1;
                exp_mem_addr = {6'd0, m_banks[idx], a[12:0]} & (m_size - 27'd1);
            end
            if (wr_v && page == 3'd3) begin
                m_banks[a[12:11]] = d;
            end
        end
        exp_dev_rd = exp_dev_en && rd_v;
    endtask

    // Each clock checks last cycle's request and rdata and presents the next access
    task automatic bus_cycle(input logic cfg_we_v, input cart_pkg::mapper_typ_e typ_v,
                             input cart_pkg::rom_size_t size_v, input logic mreq_v,
                             input logic rd_v, input logic wr_v,
                             input cart_pkg::cpu_addr_t a, input cart_pkg::cpu_data_t d);
        logic [31:0] r;
        cart_pkg::cpu_data_t exp_rdata;
        @(negedge clk);
        check_request();
        take_bits(8, r);
        dev_rdata = r[7:0];
        // ROM data follows the requested address scrambled by the LFSR
        take_bits(8, r);
        mem_rdata = exp_mem_addr[7:0] ^ r[7:0];
        cfg_we = cfg_we_v;
        cfg_typ = typ_v;
        cfg_rom_size = size_v;
        mreq = mreq_v;
        rd = rd_v;
        wr = wr_v;
        addr = a;
        wdata = d;
        #1;
        if (exp_dev_rd) begin
            exp_rdata = dev_rdata;
        end else if (exp_mem_cs) begin
            exp_rdata = mem_rdata;
        end else begin
            exp_rdata = 8'hFF;
        end
        check_value("rdata", rdata, exp_rdata);
        // The access at this edge still sees the old configuration
        predict(mreq_v, rd_v, wr_v, a, d);
        if (cfg_we_v) begin
            m_typ = typ_v;
            m_size = size_v;
        end
    endtask

    task automatic cpu_access(input logic mreq_v, input logic rd_v, input logic wr_v,
                              input cart_pkg::cpu_addr_t a, input cart_pkg::cpu_data_t d);
        bus_cycle(1'b0, cart_pkg::MAPPER_NONE, '0, mreq_v, rd_v, wr_v, a, d);
    endtask

    // Random access with mreq mostly high and never rd and wr together
    task automatic random_access(output logic mreq_v, output logic rd_v, output logic wr_v,
                                 output cart_pkg::cpu_addr_t a, output cart_pkg::cpu_data_t d);
        logic [31:0] r;
        take_bits(2, r);
        mreq_v = |r[1:0];
        take_bits(2, r);
        rd_v = r[0];
        wr_v = (r[1:0] == 2'd2);
        take_bits(16, r);
        a = r[15:0];
        take_bits(8, r);
        d = r[7:0];
    endtask

    function automatic cart_pkg::rom_size_t pow2_size(input int exp_bits);
        return cart_pkg::rom_size_t'(1) << exp_bits;
    endfunction

    task automatic idle_slot_traffic();
        logic m;
        logic rv;
        logic wv;
        cart_pkg::cpu_addr_t a;
        cart_pkg::cpu_data_t d;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            random_access(m, rv, wv, a, d);
            cpu_access(m, rv, wv, a, d);
        end
    endtask

    task automatic sfg_rom_reads();
        int sizes [SFG_SIZES] = '{13, 14, 15, 16, 20};
        logic [31:0] r;
        for (int s = 0; s < SFG_SIZES; s++) begin
            bus_cycle(1'b1, cart_pkg::MAPPER_YAMAHA_SFG, pow2_size(sizes[s]),
                      1'b0, 1'b0, 1'b0, '0, '0);
            for (int i = 0; i < SFG_READS; i++) begin
                take_bits(16, r);
                // Step out of the register window
                if (r[13:3] == SFG_WIN[13:3]) begin
                    r[3] = ~r[3];
                end
                cpu_access(1'b1, 1'b1, 1'b0, r[15:0], '0);
            end
        end
    endtask

    task automatic sfg_window_access();
        logic [31:0] r;
        logic [31:0] d;
        for (int i = 0; i < WIN_CYCLES; i++) begin
            take_bits(6, r);
            take_bits(8, d);
            // Random 16 KB mirror and window offset with either a read or a write
            cpu_access(1'b1, r[5], !r[5], {r[4:3], SFG_WIN[13:3], r[2:0]}, d[7:0]);
        end
    endtask

    task automatic ascii8_banking();
        logic [31:0] r;
        logic [31:0] d;
        take_bits(3, r);
        bus_cycle(1'b1, cart_pkg::MAPPER_ASCII8, pow2_size(16 + r[2:0] % 6),
                  1'b0, 1'b0, 1'b0, '0, '0);
        for (int k = 0; k < A8_ROUNDS; k++) begin
            for (int i = 0; i < A8_WRITES; i++) begin
                take_bits(13, r);
                take_bits(8, d);
                cpu_access(1'b1, 1'b0, 1'b1, {3'b011, r[12:0]}, d[7:0]);
            end
            // Reads span the whole address range so about half miss the pages
            for (int i = 0; i < A8_READS; i++) begin
                take_bits(16, r);
                cpu_access(1'b1, 1'b1, 1'b0, r[15:0], '0);
            end
        end
    endtask

    task automatic type_switching();
        logic [31:0] r;
        logic [31:0] e;
        logic m;
        logic rv;
        logic wv;
        cart_pkg::cpu_addr_t a;
        cart_pkg::cpu_data_t d;
        for (int b = 0; b < BURSTS; b++) begin
            take_bits(2, r);
            take_bits(4, e);
            random_access(m, rv, wv, a, d);
            // New type is written together with an access that must use the old one
            bus_cycle(1'b1, cart_pkg::mapper_typ_e'(r[1:0] % 3), pow2_size(13 + e % 14),
                      m, rv, wv, a, d);
            for (int i = 0; i < BURST_LEN; i++) begin
                random_access(m, rv, wv, a, d);
                cpu_access(m, rv, wv, a, d);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    initial begin
        cfg_we = 1'b0;
        cfg_typ = cart_pkg::MAPPER_NONE;
        cfg_rom_size = '0;
        mreq = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        wdata = '0;
        mem_rdata = '0;
        dev_rdata = '0;
        lfsr_q = 32'h2f782b31;
        cycle_cnt = 0;
        // Model starts in the reset state of the DUT
        m_typ = cart_pkg::MAPPER_NONE;
        m_size = '0;
        for (int i = 0; i < `CART_ASCII8_BANKS; i++) begin
            m_banks[i] = '0;
        end
        exp_mem_cs = 1'b0;
        exp_mem_addr = `CART_IDLE_ADDR;
        exp_dev_en = 1'b0;
        exp_dev_we = 1'b0;
        exp_dev_rd = 1'b0;
        exp_dev_wdata = '0;
        @(posedge arst_n);
        idle_slot_traffic();
        sfg_rom_reads();
        sfg_window_access();
        ascii8_banking();
        type_switching();
        // Two idle cycles so the final access is checked too
        cpu_access(1'b0, 1'b0, 1'b0, '0, '0);
        cpu_access(1'b0, 1'b0, 1'b0, '0, '0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- cart_slot.f
+incdir+common
common/cart_pkg.sv
src/slot_decode.sv
src/mapper/mapper_yamaha_sfg.sv
src/mapper/mapper_ascii8.sv
src/slot_result.sv
src/cart_slot_top.sv
tb/tb_clk_gen.sv
tb/tb_cart_slot.sv

//--- Bender.yml
package:
  name: cart_slot

export_include_dirs:
  - common

sources:
  - common/cart_pkg.sv
  - src/slot_decode.sv
  - src/mapper/mapper_yamaha_sfg.sv
  - src/mapper/mapper_ascii8.sv
  - src/slot_result.sv
  - src/cart_slot_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_cart_slot.sv
